// File: list.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_core_top.sv
tests/tb_clk_gen.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_core_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/register_file.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_stage.sv
      - verilog/rv_core_top.sv
      - target: test
        files:
          - tests/tb_clk_gen.sv
          - tests/rv_core_chk.sv
          - tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
`include "rv_core_defs.svh"

module rv_core_tb;

    // About 165 instructions at 4 cycles each with stalls, plus margin
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        arst_n;
    logic        istall;
    logic        dstall;
    logic        stall_on;
    logic        icache_ren;
    logic [29:0] icache_addr;
    logic [31:0] icache_rdata;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    logic [31:0] dcache_wdata;
    logic [31:0] dcache_rdata;
    logic [31:0] pc;
    logic [31:0] prog [64];
    logic [31:0] imem [64];
    logic [31:0] dmem [32];
    logic [29:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] halt_pc;
    logic        halt_seen = 1'b0;
    int          store_idx = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles;
    integer      seed = 52846;

    tb_clk_gen #(.PERIOD(4)) u_clk (.clk_o(clk));

    rv_core_top UUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .icache_ren_o   (icache_ren),
        .icache_addr_o  (icache_addr),
        .icache_rdata_i (icache_rdata),
        .icache_stall_i (istall),
        .dcache_ren_o   (dcache_ren),
        .dcache_wen_o   (dcache_wen),
        .dcache_addr_o  (dcache_addr),
        .dcache_wdata_o (dcache_wdata),
        .dcache_rdata_i (dcache_rdata),
        .dcache_stall_i (dstall),
        .pc_o           (pc)
    );

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h9E37_0000 + idx * 32'h0003_0105;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            prog[i] = `RV_NOP;
        end
        prog[0]  = i_word(`RV_OP_OPIMM, 12'd5, 5'd0, 3'b000, 5'd1);
        prog[1]  = i_word(`RV_OP_OPIMM, 12'hFFD, 5'd0, 3'b000, 5'd2);
        // Operands from MEM and WB at once
        prog[2]  = r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        prog[3]  = r_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
        prog[4]  = r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd5);
        prog[5]  = r_word(7'h00, 5'd3, 5'd4, 3'b100, 5'd6);
        prog[6]  = r_word(7'h00, 5'd5, 5'd1, 3'b001, 5'd7);
        prog[7]  = r_word(7'h00, 5'd5, 5'd2, 3'b101, 5'd8);
        prog[8]  = s_word(12'd0, 5'd3, 5'd0);
        prog[9]  = s_word(12'd4, 5'd4, 5'd0);
        prog[10] = s_word(12'd8, 5'd6, 5'd0);
        prog[11] = s_word(12'd12, 5'd8, 5'd0);
        prog[12] = {20'h12345, 5'd9, `RV_OP_LUI};
        prog[13] = i_word(`RV_OP_OPIMM, 12'h678, 5'd9, 3'b110, 5'd9);
        prog[14] = i_word(`RV_OP_OPIMM, 12'h0F0, 5'd9, 3'b111, 5'd10);
        prog[15] = i_word(`RV_OP_OPIMM, 12'hFFF, 5'd10, 3'b100, 5'd11);
        prog[16] = i_word(`RV_OP_OPIMM, 12'd0, 5'd11, 3'b010, 5'd12);
        prog[17] = r_word(7'h00, 5'd12, 5'd7, 3'b110, 5'd13);
        prog[18] = r_word(7'h00, 5'd11, 5'd9, 3'b111, 5'd14);
        prog[19] = s_word(12'd16, 5'd9, 5'd0);
        prog[20] = s_word(12'd20, 5'd14, 5'd0);
        // Load-use through rs1, then through store data
        prog[21] = i_word(`RV_OP_LOAD, 12'd16, 5'd0, 3'b010, 5'd15);
        prog[22] = i_word(`RV_OP_OPIMM, 12'd1, 5'd15, 3'b000, 5'd15);
        prog[23] = s_word(12'd24, 5'd15, 5'd0);
        prog[24] = i_word(`RV_OP_LOAD, 12'd100, 5'd0, 3'b010, 5'd1);
        prog[25] = s_word(12'd28, 5'd1, 5'd0);
        prog[26] = s_word(12'd112, 5'd13, 5'd0);
        prog[27] = i_word(`RV_OP_OPIMM, 12'd0, 5'd0, 3'b000, 5'd10);
        prog[28] = i_word(`RV_OP_OPIMM, 12'd20, 5'd0, 3'b000, 5'd11);
        prog[29] = i_word(`RV_OP_OPIMM, 12'd32, 5'd0, 3'b000, 5'd12);
        // Loop of 20 passes over words 8 to 27
        prog[30] = i_word(`RV_OP_LOAD, 12'd0, 5'd12, 3'b010, 5'd13);
        prog[31] = r_word(7'h00, 5'd10, 5'd13, 3'b000, 5'd13);
        prog[32] = s_word(12'd0, 5'd13, 5'd12);
        prog[33] = i_word(`RV_OP_OPIMM, 12'd4, 5'd12, 3'b000, 5'd12);
        prog[34] = i_word(`RV_OP_OPIMM, 12'd1, 5'd10, 3'b000, 5'd10);
        prog[35] = b_word(13'h1FEC, 5'd11, 5'd10, 3'b001);
        prog[36] = b_word(13'd8, 5'd11, 5'd10, 3'b000);
        prog[37] = s_word(12'd0, 5'd0, 5'd0);
        prog[38] = b_word(13'd8, 5'd0, 5'd10, 3'b000);
        prog[39] = j_word(21'd12, 5'd5);
        prog[40] = s_word(12'd4, 5'd0, 5'd0);
        prog[41] = s_word(12'd8, 5'd0, 5'd0);
        prog[42] = s_word(12'd124, 5'd5, 5'd0);
        // Odd base, JALR clears bit 0
        prog[43] = i_word(`RV_OP_OPIMM, 12'd189, 5'd0, 3'b000, 5'd6);
        prog[44] = i_word(`RV_OP_JALR, 12'd0, 5'd6, 3'b000, 5'd7);
        prog[45] = s_word(12'd0, 5'd0, 5'd0);
        prog[46] = s_word(12'd0, 5'd0, 5'd0);
        prog[47] = s_word(12'd120, 5'd7, 5'd0);
        prog[48] = j_word(21'd0, 5'd0);
    endtask

    // Instruction-level model of the program, fills the expected store list
    function automatic void iss_run();
        logic [31:0] x [32];
        logic [31:0] mem [32];
        logic [31:0] ins;
        logic [31:0] cur_pc;
        logic [31:0] nxt_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [4:0]  rd;
        for (int i = 0; i < 32; i++) begin
            x[i]   = '0;
            mem[i] = fill_word(i);
        end
        cur_pc = `RV_RESET_PC;
        for (int step = 0; step < 1000; step++) begin
            ins = prog[cur_pc[7:2]];
            if (ins == j_word(21'd0, 5'd0)) begin
                break;
            end
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            rd     = ins[11:7];
            imm_i  = {{20{ins[31]}}, ins[31:20]};
            nxt_pc = cur_pc + 32'd4;
            case (ins[6:0])
                `RV_OP_LUI: x[rd] = {ins[31:12], 12'h000};
                `RV_OP_OPIMM, `RV_OP_OP: begin
                    if (ins[6:0] == `RV_OP_OPIMM) begin
                        b = imm_i;
                    end
                    case (ins[14:12])
                        3'b000: x[rd] = (ins[6:0] == `RV_OP_OP && ins[30]) ? a - b : a + b;
                        3'b001: x[rd] = a << b[4:0];
                        3'b010: x[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100: x[rd] = a ^ b;
                        3'b101: x[rd] = a >> b[4:0];
                        3'b110: x[rd] = a | b;
                        default: x[rd] = a & b;
                    endcase
                end
                `RV_OP_LOAD: begin
                    addr  = a + imm_i;
                    x[rd] = mem[addr[6:2]];
                end
                `RV_OP_STORE: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[6:2]] = b;
                    exp_addr.push_back(addr[31:2]);
                    exp_data.push_back(b);
                end
                `RV_OP_BRANCH: begin
                    if ((a == b) != ins[12]) begin
                        nxt_pc = cur_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                           ins[11:8], 1'b0};
                    end
                end
                `RV_OP_JAL: begin
                    x[rd]  = cur_pc + 32'd4;
                    nxt_pc = cur_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                       ins[30:21], 1'b0};
                end
                `RV_OP_JALR: begin
                    nxt_pc = (a + imm_i) & ~32'd1;
                    x[rd]  = cur_pc + 32'd4;
                end
                default: ;
            endcase
            x[0]   = '0;
            cur_pc = nxt_pc;
        end
        halt_pc = cur_pc;
    endfunction

    // Caches answer in the same cycle while the read strobe is high
    assign icache_rdata = icache_ren ? imem[icache_addr[5:0]] : 'x;
    assign dcache_rdata = dcache_ren ? dmem[dcache_addr[4:0]] : 'x;

    always @(negedge clk) begin
        if (arst_n && dcache_wen && !istall && !dstall) begin
            dmem[dcache_addr[4:0]] = dcache_wdata;
        end
    end

    always @(posedge clk) begin
        #1;
        if (stall_on) begin
            istall = ($random(seed) & 7) == 0;
            dstall = ($random(seed) & 7) == 0;
        end
    end

    // Store checker
    always @(negedge clk) begin
        if (arst_n && pc == halt_pc) begin
            halt_seen = 1'b1;
        end
        if (arst_n && dcache_wen && !istall && !dstall) begin
            assert (store_idx < exp_data.size()) else begin
                other_errs++;
                $display("store beyond the expected list at %0t, address %h", $time,
                         dcache_addr);
            end
            if (store_idx < exp_data.size()) begin
                assert (dcache_addr == exp_addr[store_idx]) else begin
                    value_errs++;
                    $display("ERR %0t dcache_addr_o got %h expected %h", $time,
                             dcache_addr, exp_addr[store_idx]);
                end
                assert (dcache_wdata == swap_bytes(exp_data[store_idx])) else begin
                    value_errs++;
                    $display("ERR %0t dcache_wdata_o got %h expected %h", $time,
                             dcache_wdata, swap_bytes(exp_data[store_idx]));
                end
                store_idx++;
            end
        end
    end

    initial begin
        arst_n   = 1'b0;
        istall   = 1'b0;
        dstall   = 1'b0;
        stall_on = 1'b0;
        load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = swap_bytes(prog[i]);
        end
        for (int i = 0; i < 32; i++) begin
            dmem[i] = swap_bytes(fill_word(i));
        end
        iss_run();
        repeat (5) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        stall_on = 1'b1;
        cycles   = 0;
        while (!(halt_seen && store_idx == exp_data.size()) && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        // Stray stores from flushed slots would show up here
        repeat (20) @(posedge clk);
        assert (cycles < MAX_CYCLES) else begin
            other_errs++;
            $display("timeout after %0d cycles without reaching the halt loop", cycles);
        end
        assert (store_idx == exp_data.size()) else begin
            other_errs++;
            $display("saw %0d stores but expected %0d", store_idx, exp_data.size());
        end
        assert (halt_seen) else begin
            other_errs++;
            $display("pc_o never reached the halt address %h", halt_pc);
        end
        assert (UUT.u_chk.fail_cnt == 0) else begin
            other_errs++;
            $display("bound pipeline assertions failed %0d times", UUT.u_chk.fail_cnt);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/rv_core_chk.sv
module rv_core_chk (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        dcache_ren_i,
    input logic        dcache_wen_i,
    input logic        icache_stall_i,
    input logic        dcache_stall_i,
    input logic [31:0] pc_i
);

    int fail_cnt = 0;

    // A word is either loaded or stored, never both
    strobe_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(dcache_ren_i && dcache_wen_i))
        else begin
            $error("data cache read and write strobes high in the same cycle");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> (!dcache_ren_i && !dcache_wen_i))
        else begin
            $error("data cache strobe active during reset");
            fail_cnt++;
        end

    // Frozen pipeline keeps the fetch address
    pc_frozen: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (icache_stall_i || dcache_stall_i) |=> $stable(pc_i))
        else begin
            $error("pc_o moved while a cache stall was high");
            fail_cnt++;
        end

    pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pc_i[1:0] == 2'b00)
        else begin
            $error("pc_o is not word aligned");
            fail_cnt++;
        end

endmodule

bind rv_core_top rv_core_chk u_chk (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .dcache_ren_i   (dcache_ren_o),
    .dcache_wen_i   (dcache_wen_o),
    .icache_stall_i (icache_stall_i),
    .dcache_stall_i (dcache_stall_i),
    .pc_i           (pc_o)
);

// File: tests/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: verilog/rv_core_top.sv
module rv_core_top (
    input  logic        clk_i,
    input  logic        arst_n_i,
    output logic        icache_ren_o,
    output logic [29:0] icache_addr_o,
    input  logic [31:0] icache_rdata_i,
    input  logic        icache_stall_i,
    output logic        dcache_ren_o,
    output logic        dcache_wen_o,
    output logic [29:0] dcache_addr_o,
    output logic [31:0] dcache_wdata_o,
    input  logic [31:0] dcache_rdata_i,
    input  logic        dcache_stall_i,
    output logic [31:0] pc_o
);
    import rv_core_pkg::*;

    logic       freeze;
    logic       hold;
    logic [4:0] ex_rd;
    logic       ex_mem_read;
    redirect_t  redirect;
    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    wb_t        wb;

    // Either cache stalling freezes the whole pipeline
    assign freeze        = icache_stall_i | dcache_stall_i;
    assign icache_ren_o  = 1'b1;
    assign icache_addr_o = pc_o[31:2];

    fetch_stage u_fetch (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .freeze_i       (freeze),
        .hold_i         (hold),
        .redirect_i     (redirect),
        .icache_rdata_i (icache_rdata_i),
        .pc_o           (pc_o),
        .if_id_o        (if_id)
    );

    decode_stage u_decode (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .freeze_i      (freeze),
        .flush_i       (redirect.taken),
        .if_id_i       (if_id),
        .ex_rd_i       (ex_rd),
        .ex_mem_read_i (ex_mem_read),
        .wb_i          (wb),
        .hold_o        (hold),
        .id_ex_o       (id_ex)
    );

    execute_stage u_execute (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .freeze_i      (freeze),
        .id_ex_i       (id_ex),
        .mem_fwd_i     (ex_mem),
        .wb_i          (wb),
        .redirect_o    (redirect),
        .ex_rd_o       (ex_rd),
        .ex_mem_read_o (ex_mem_read),
        .ex_mem_o      (ex_mem)
    );

    memory_stage u_memory (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .freeze_i       (freeze),
        .ex_mem_i       (ex_mem),
        .dcache_rdata_i (dcache_rdata_i),
        .dcache_ren_o   (dcache_ren_o),
        .dcache_wen_o   (dcache_wen_o),
        .dcache_addr_o  (dcache_addr_o),
        .dcache_wdata_o (dcache_wdata_o),
        .wb_o           (wb)
    );

endmodule

// File: verilog/memory_stage.sv
module memory_stage (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 freeze_i,
    input  rv_core_pkg::ex_mem_t ex_mem_i,
    input  logic [31:0]          dcache_rdata_i,
    output logic                 dcache_ren_o,
    output logic                 dcache_wen_o,
    output logic [29:0]          dcache_addr_o,
    output logic [31:0]          dcache_wdata_o,
    output rv_core_pkg::wb_t     wb_o
);
    import rv_core_pkg::*;

    logic [31:0] load_data;
    wb_t         wb_d;
    wb_t         wb_q;

    assign dcache_ren_o  = ex_mem_i.mem_read;
    assign dcache_wen_o  = ex_mem_i.mem_write;
    assign dcache_addr_o = ex_mem_i.result[31:2];

    // Big-endian words on the cache side
    assign dcache_wdata_o = {<<8{ex_mem_i.store_data}};
    assign load_data      = {<<8{dcache_rdata_i}};

    always_comb begin
        wb_d.reg_write = ex_mem_i.reg_write;
        wb_d.rd        = ex_mem_i.rd;
        wb_d.data      = ex_mem_i.mem_read ? load_data : ex_mem_i.result;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else if (!freeze_i) begin
            wb_q <= wb_d;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   freeze_i,
    input  rv_core_pkg::id_ex_t    id_ex_i,
    input  rv_core_pkg::ex_mem_t   mem_fwd_i,
    input  rv_core_pkg::wb_t       wb_i,
    output rv_core_pkg::redirect_t redirect_o,
    output logic [4:0]             ex_rd_o,
    output logic                   ex_mem_read_o,
    output rv_core_pkg::ex_mem_t   ex_mem_o
);
    import rv_core_pkg::*;

    logic [31:0] op_a;
    logic [31:0] rs2_fwd;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        cond_met;
    ex_mem_t     ex_mem_d;
    ex_mem_t     ex_mem_q;

    // MEM has priority over WB, it holds the younger result
    function automatic logic [31:0] forward(input logic [4:0] addr, input logic [31:0] reg_data);
        if (addr != 5'd0 && mem_fwd_i.reg_write && mem_fwd_i.rd == addr) begin
            return mem_fwd_i.result;
        end
        if (addr != 5'd0 && wb_i.reg_write && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return reg_data;
    endfunction

    always_comb begin
        op_a    = forward(id_ex_i.rs1_addr, id_ex_i.rs1_data);
        rs2_fwd = forward(id_ex_i.rs2_addr, id_ex_i.rs2_data);
        alu_b   = id_ex_i.alu_src_imm ? id_ex_i.imm : rs2_fwd;
    end

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add: alu_out = op_a + alu_b;
            alu_sub: alu_out = op_a - alu_b;
            alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            alu_xor: alu_out = op_a ^ alu_b;
            alu_or:  alu_out = op_a | alu_b;
            alu_and: alu_out = op_a & alu_b;
            alu_sll: alu_out = op_a << alu_b[4:0];
            alu_srl: alu_out = op_a >> alu_b[4:0];
            default: alu_out = alu_b;
        endcase
    end

    // BEQ when funct3 bit 0 is clear, BNE when set
    assign cond_met = (op_a == rs2_fwd) != id_ex_i.branch_ne;

    assign redirect_o.taken  = id_ex_i.valid &&
                               (id_ex_i.jump || (id_ex_i.branch && cond_met));
    assign redirect_o.target = id_ex_i.jalr ? ((op_a + id_ex_i.imm) & ~32'd1)
                                            : (id_ex_i.pc + id_ex_i.imm);

    always_comb begin
        ex_mem_d.reg_write  = id_ex_i.valid & id_ex_i.reg_write;
        ex_mem_d.mem_read   = id_ex_i.valid & id_ex_i.mem_read;
        ex_mem_d.mem_write  = id_ex_i.valid & id_ex_i.mem_write;
        ex_mem_d.result     = id_ex_i.jump ? id_ex_i.pc_plus4 : alu_out;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.rd         = id_ex_i.rd;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else if (!freeze_i) begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign ex_rd_o       = id_ex_i.rd;
    assign ex_mem_read_o = id_ex_i.valid & id_ex_i.mem_read;
    assign ex_mem_o      = ex_mem_q;

endmodule

// File: verilog/decode_stage.sv
`include "rv_core_defs.svh"

module decode_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                freeze_i,
    input  logic                flush_i,
    input  rv_core_pkg::if_id_t if_id_i,
    input  logic [4:0]          ex_rd_i,
    input  logic                ex_mem_read_i,
    input  rv_core_pkg::wb_t    wb_i,
    output logic                hold_o,
    output rv_core_pkg::id_ex_t id_ex_o
);
    import rv_core_pkg::*;

    rv_instr_u   instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        use_rs1;
    logic        use_rs2;
    wb_t         rf_wb;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b101:  return alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign instr = if_id_i.instr;

    // No register write while the pipeline is frozen
    always_comb begin
        rf_wb           = wb_i;
        rf_wb.reg_write = wb_i.reg_write & ~freeze_i;
    end

    register_file u_regs (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr.r_fmt.rs1),
        .rs2_addr_i (instr.r_fmt.rs2),
        .wb_i       (rf_wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.rs1_addr = instr.r_fmt.rs1;
        id_ex_d.rs2_addr = instr.r_fmt.rs2;
        id_ex_d.rd       = instr.r_fmt.rd;
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.pc_plus4 = if_id_i.pc_plus4;
        id_ex_d.alu_op   = alu_add;
        use_rs1          = 1'b1;
        use_rs2          = 1'b0;
        case (instr.r_fmt.opcode)
            `RV_OP_LUI: begin
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.alu_op      = alu_pass_b;
                id_ex_d.imm         = {instr.j_fmt.imm_20, instr.j_fmt.imm_10_1,
                                       instr.j_fmt.imm_11, instr.j_fmt.imm_19_12, 12'h000};
                use_rs1             = 1'b0;
            end
            `RV_OP_OPIMM: begin
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.alu_op      = alu_from_funct3(instr.i_fmt.funct3, 1'b0);
                id_ex_d.imm         = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            `RV_OP_OP: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = alu_from_funct3(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
                use_rs2           = 1'b1;
            end
            `RV_OP_LOAD: begin
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.mem_read    = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.imm         = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            `RV_OP_STORE: begin
                id_ex_d.mem_write   = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.imm         = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                                       instr.s_fmt.imm_lo};
                use_rs2             = 1'b1;
            end
            `RV_OP_BRANCH: begin
                id_ex_d.branch    = 1'b1;
                id_ex_d.branch_ne = instr.b_fmt.funct3[0];
                id_ex_d.imm       = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
                use_rs2           = 1'b1;
            end
            `RV_OP_JAL: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.jump      = 1'b1;
                id_ex_d.imm       = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                                     instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
                use_rs1           = 1'b0;
            end
            `RV_OP_JALR: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.jump      = 1'b1;
                id_ex_d.jalr      = 1'b1;
                id_ex_d.imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            default: begin
                use_rs1 = 1'b0;
            end
        endcase
    end

    // Load in EX feeding a source of this instruction
    assign hold_o = ex_mem_read_i && (ex_rd_i != 5'd0) &&
                    ((use_rs1 && ex_rd_i == instr.r_fmt.rs1) ||
                     (use_rs2 && ex_rd_i == instr.r_fmt.rs2));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (!freeze_i) begin
            id_ex_q       <= id_ex_d;
            // Bubble on redirect or load-use
            id_ex_q.valid <= !(flush_i || hold_o);
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// File: verilog/register_file.sv
module register_file (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    input  rv_core_pkg::wb_t wb_i,
    output logic [31:0]      rs1_data_o,
    output logic [31:0]      rs2_data_o
);

    logic [31:0] regs_q [1:31];

    // x0 reads zero, a same-cycle write is seen at once
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wb_i.reg_write && wb_i.rd == addr) begin
            return wb_i.data;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.reg_write && wb_i.rd != 5'd0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// File: verilog/fetch_stage.sv
`include "rv_core_defs.svh"

module fetch_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   freeze_i,
    input  logic                   hold_i,
    input  rv_core_pkg::redirect_t redirect_i,
    input  logic [31:0]            icache_rdata_i,
    output logic [31:0]            pc_o,
    output rv_core_pkg::if_id_t    if_id_o
);
    import rv_core_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;
    logic [31:0] instr_word;
    if_id_t      if_id_q;

    assign pc_plus4 = pc_q + 32'd4;

    // Cache stores words big-endian
    assign instr_word = {<<8{icache_rdata_i}};

    // Redirect wins over a load-use hold
    always_comb begin
        if (redirect_i.taken) begin
            pc_next = redirect_i.target;
        end else if (hold_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (!freeze_i) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_q <= '{instr: `RV_NOP, pc: '0, pc_plus4: '0};
        end else if (!freeze_i) begin
            if (redirect_i.taken) begin
                if_id_q.instr <= `RV_NOP;
            end else if (!hold_i) begin
                if_id_q.instr    <= instr_word;
                if_id_q.pc       <= pc_q;
                if_id_q.pc_plus4 <= pc_plus4;
            end
        end
    end

    assign pc_o    = pc_q;
    assign if_id_o = if_id_q;

endmodule

// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, read through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        rv_instr_u   instr;
        logic [31:0] pc;
        logic [31:0] pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        logic        jalr;
        logic        alu_src_imm;
        alu_op_e     alu_op;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

endpackage

// File: verilog/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

`define RV_RESET_PC   32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP        32'h0000_0013

// Major opcodes of the supported subset
`define RV_OP_LUI     7'b0110111
`define RV_OP_OPIMM   7'b0010011
`define RV_OP_OP      7'b0110011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111

`endif
